// ==== cp0_exc_top.f ====
+incdir+logic
logic/cp0_reg_pkg.sv
logic/exc_pkg.sv
logic/exc_prioritize.sv
logic/cp0_regfile.sv
logic/exc_redirect.sv
logic/cp0_wb_port.sv
logic/cp0_exc_top.sv
test/cp0_exc_asserts.sv
test/cp0_exc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cp0 exception testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module cp0_exc_tb -f cp0_exc_top.f -o sim_cp0_exc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_cp0_exc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/cp0_exc_tb.sv ====
`timescale 1ns/10ps

module cp0_exc_tb;

   localparam int SCENARIO_CYCLES = 80;  // host reads, writes and fault slots
   localparam int TIMER_WAIT      = 120; // count runs at half rate up to compare
   localparam int WATCHDOG_CYCLES = 2 * (SCENARIO_CYCLES + TIMER_WAIT);
   localparam int ACK_LIMIT       = 8;
   localparam logic [31:0] BOOT_GENERAL = 32'hBFC0_0380; // boot base + 0x180

   logic        clk;
   logic        rst;
   logic        inst_valid_i;
   logic [31:0] inst_pc_i;
   logic        in_delay_slot_i;
   logic [31:0] data_addr_i;
   logic        mem_read_i;
   logic        mem_write_i;
   logic        pc_misalign_i;
   logic        load_misalign_i;
   logic        store_misalign_i;
   logic        itlb_refill_i;
   logic        itlb_invalid_i;
   logic        dtlb_refill_i;
   logic        dtlb_invalid_i;
   logic        dtlb_modify_i;
   logic        ri_i;
   logic        syscall_i;
   logic        break_i;
   logic        overflow_i;
   logic        trap_i;
   logic        eret_i;
   logic [5:0]  int_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        wb_ack_o;
   logic [31:0] wb_dat_o;
   logic        flush_o;
   logic [31:0] redirect_pc_o;

   logic [15:0] lfsr_q;
   logic [31:0] ebase_exp; // ebase after the host write
   int          check_count;
   int          error_count;

   cp0_exc_top i_cp0_exc_top (.*);

   always #50 clk = ~clk;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic random_bits(input int n, output logic [31:0] w);
      w = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         w = {w[30:0], lfsr_q[0]};
      end
   endtask

   task automatic random_pc(output logic [31:0] pc);
      logic [31:0] w;
      random_bits(30, w);
      pc = {w[29:0], 2'b00}; // word aligned
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      check_count++;
      assert (actual === expected) else begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic clear_inst();
      inst_valid_i     = 1'b0;
      inst_pc_i        = '0;
      in_delay_slot_i  = 1'b0;
      data_addr_i      = '0;
      mem_read_i       = 1'b0;
      mem_write_i      = 1'b0;
      pc_misalign_i    = 1'b0;
      load_misalign_i  = 1'b0;
      store_misalign_i = 1'b0;
      itlb_refill_i    = 1'b0;
      itlb_invalid_i   = 1'b0;
      dtlb_refill_i    = 1'b0;
      dtlb_invalid_i   = 1'b0;
      dtlb_modify_i    = 1'b0;
      ri_i             = 1'b0;
      syscall_i        = 1'b0;
      break_i          = 1'b0;
      overflow_i       = 1'b0;
      trap_i           = 1'b0;
      eret_i           = 1'b0;
   endtask

   // request already on the bus, ends 10 ns after the ack edge
   task automatic await_ack(input string name);
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         #10;
         waited++;
      end while (!wb_ack_o && waited < ACK_LIMIT);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      check_count++;
      assert (wb_ack_o) else begin
         $display("%s: no wishbone ack within %0d cycles", name, ACK_LIMIT);
         error_count++;
      end
   endtask

   task automatic host_write(input string name, input cp0_reg_pkg::reg_num_t regnum,
                             input cp0_reg_pkg::reg_sel_t sel, input logic [31:0] data);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = {22'd0, sel, regnum, 2'b00};
      wb_dat_i = data;
      await_ack(name);
   endtask

   task automatic host_read(input string name, input cp0_reg_pkg::reg_num_t regnum,
                            input cp0_reg_pkg::reg_sel_t sel, output logic [31:0] data);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b0;
      wb_adr_i = {22'd0, sel, regnum, 2'b00};
      await_ack(name);
      data = wb_dat_o;
   endtask

   task automatic read_check(input string name, input cp0_reg_pkg::reg_num_t regnum,
                             input cp0_reg_pkg::reg_sel_t sel, input logic [31:0] expected);
      logic [31:0] rd;
      host_read(name, regnum, sel, rd);
      check_word(name, expected, rd);
   endtask

   // slot is driven by the caller, flush lands two edges later
   task automatic expect_redirect(input string name, input logic [31:0] target);
      @(posedge clk);
      #10;
      clear_inst();
      @(posedge clk);
      #10;
      check_word({name, " flush"}, 32'd1, 32'(flush_o));
      check_word({name, " target"}, target, redirect_pc_o);
      @(posedge clk);
      #10;
      check_word({name, " flush pulse"}, 32'd0, 32'(flush_o));
   endtask

   task automatic check_reset_values();
      // first edge out of reset still sees random at its top
      read_check("reset random", cp0_reg_pkg::REG_RANDOM, 3'd0, 32'd15);
      read_check("reset status", cp0_reg_pkg::REG_STATUS, 3'd0, 32'h0040_0000);
      read_check("reset prid", cp0_reg_pkg::REG_PRID, 3'd0, 32'h0001_8003);
      read_check("reset ebase", cp0_reg_pkg::REG_PRID, cp0_reg_pkg::REG_EBASE_SEL,
                 32'h8000_0000);
   endtask

   task automatic run_syscall();
      logic [31:0] pc;
      logic [31:0] rd;
      random_pc(pc);
      inst_valid_i = 1'b1;
      inst_pc_i    = pc;
      syscall_i    = 1'b1;
      expect_redirect("syscall", BOOT_GENERAL);
      read_check("syscall epc", cp0_reg_pkg::REG_EPC, 3'd0, pc);
      host_read("syscall cause", cp0_reg_pkg::REG_CAUSE, 3'd0, rd);
      check_word("syscall exccode", 32'd8, 32'(rd[6:2]));
      check_word("syscall bd", 32'd0, 32'(rd[31]));
      host_read("syscall status", cp0_reg_pkg::REG_STATUS, 3'd0, rd);
      check_word("syscall exl", 32'd1, 32'(rd[1]));
   endtask

   task automatic run_load_misalign();
      logic [31:0] pc;
      logic [31:0] addr;
      logic [31:0] rd;
      random_pc(pc);
      random_bits(32, addr);
      addr[0] = 1'b1; // odd, so a word load is misaligned
      inst_valid_i    = 1'b1;
      inst_pc_i       = pc;
      in_delay_slot_i = 1'b1;
      data_addr_i     = addr;
      mem_read_i      = 1'b1;
      load_misalign_i = 1'b1;
      overflow_i      = 1'b1; // loses to adel
      expect_redirect("load misalign", BOOT_GENERAL);
      read_check("load misalign epc", cp0_reg_pkg::REG_EPC, 3'd0, pc - 32'd4);
      host_read("load misalign cause", cp0_reg_pkg::REG_CAUSE, 3'd0, rd);
      check_word("load misalign exccode", 32'd4, 32'(rd[6:2]));
      check_word("load misalign bd", 32'd1, 32'(rd[31]));
      read_check("load misalign badvaddr", cp0_reg_pkg::REG_BADVADDR, 3'd0, addr);
   endtask

   task automatic run_eret();
      logic [31:0] epc;
      logic [31:0] rd;
      host_read("eret epc", cp0_reg_pkg::REG_EPC, 3'd0, epc);
      inst_valid_i = 1'b1;
      inst_pc_i    = BOOT_GENERAL;
      eret_i       = 1'b1;
      expect_redirect("eret", epc);
      host_read("eret status", cp0_reg_pkg::REG_STATUS, 3'd0, rd);
      check_word("eret exl", 32'd0, 32'(rd[1]));
   endtask

   task automatic run_tlb_vectors();
      logic [31:0] ebase_w;
      logic [31:0] pc;
      logic [31:0] addr;
      logic [31:0] rd;
      ebase_w   = 32'h1234_5678;
      ebase_exp = 32'h8000_0000 | (ebase_w & 32'h3FFF_F000); // bits 29:12 only
      host_write("clear bev", cp0_reg_pkg::REG_STATUS, 3'd0, 32'h0000_0000);
      host_write("ebase", cp0_reg_pkg::REG_PRID, cp0_reg_pkg::REG_EBASE_SEL, ebase_w);
      read_check("ebase", cp0_reg_pkg::REG_PRID, cp0_reg_pkg::REG_EBASE_SEL, ebase_exp);

      random_pc(pc);
      random_bits(32, addr);
      inst_valid_i  = 1'b1;
      inst_pc_i     = pc;
      data_addr_i   = addr;
      mem_write_i   = 1'b1;
      dtlb_refill_i = 1'b1;
      expect_redirect("dtlb refill", ebase_exp);
      host_read("dtlb refill cause", cp0_reg_pkg::REG_CAUSE, 3'd0, rd);
      check_word("dtlb refill exccode", 32'd3, 32'(rd[6:2]));
      host_read("dtlb refill entryhi", cp0_reg_pkg::REG_ENTRYHI, 3'd0, rd);
      check_word("dtlb refill vpn2", 32'(addr[31:13]), 32'(rd[31:13]));

      random_pc(pc);
      inst_valid_i   = 1'b1;
      inst_pc_i      = pc;
      itlb_invalid_i = 1'b1;
      expect_redirect("itlb invalid", ebase_exp + 32'h180);
      read_check("itlb invalid badvaddr", cp0_reg_pkg::REG_BADVADDR, 3'd0, pc);
   endtask

   task automatic run_timer_interrupt();
      logic [31:0] count;
      logic [31:0] pc;
      logic [31:0] rd;
      int          waited;
      host_read("count", cp0_reg_pkg::REG_COUNT, 3'd0, count);
      host_write("compare", cp0_reg_pkg::REG_COMPARE, 3'd0, count + 32'd24);
      host_write("ie im7", cp0_reg_pkg::REG_STATUS, 3'd0, 32'h0000_8001);
      random_pc(pc);
      inst_valid_i = 1'b1;
      inst_pc_i    = pc;
      waited = 0;
      do begin
         @(posedge clk);
         #10;
         waited++;
      end while (!flush_o && waited < TIMER_WAIT);
      clear_inst();
      check_count++;
      assert (flush_o) else begin
         $display("timer interrupt gave no flush within %0d cycles", TIMER_WAIT);
         error_count++;
      end
      check_word("timer target", ebase_exp + 32'h180, redirect_pc_o);
      host_read("timer cause", cp0_reg_pkg::REG_CAUSE, 3'd0, rd);
      check_word("timer exccode", 32'd0, 32'(rd[6:2]));
      check_word("timer ip7", 32'd1, 32'(rd[15]));
   endtask

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      int_i       = '0;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      lfsr_q      = 16'd51119;
      ebase_exp   = 32'h8000_0000;
      check_count = 0;
      error_count = 0;
      clear_inst();
      repeat (2) @(posedge clk);
      #10;
      rst = 1'b0;

      check_reset_values();
      run_syscall();
      run_load_misalign();
      run_eret();
      run_tlb_vectors();
      run_timer_interrupt();

      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== test/cp0_exc_asserts.sv ====
`timescale 1ns/10ps

module cp0_exc_asserts (
   input logic clk,
   input logic rst,
   input logic inst_valid_i,
   input logic fault_any_i,
   input logic flush_i,
   input logic wb_cyc_i,
   input logic wb_stb_i,
   input logic wb_ack_i
);

   // ack answers a request seen on the edge before
   ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
      else $error("wishbone ack without a request in the previous cycle");

   ack_single: assert property (@(posedge clk) disable iff (rst)
      wb_ack_i |=> !wb_ack_i)
      else $error("wishbone ack held longer than one cycle");

   // sampled at edge n, flush seen at edge n+2
   flush_after_fault: assert property (@(posedge clk) disable iff (rst)
      $past(inst_valid_i && !flush_i && fault_any_i, 2) |-> flush_i)
      else $error("faulting instruction not flushed two cycles later");

   flush_has_source: assert property (@(posedge clk) disable iff (rst)
      flush_i |-> $past(inst_valid_i, 2))
      else $error("flush without a valid instruction two cycles earlier");

   flush_low_after_reset: assert property (@(posedge clk)
      rst |=> !flush_i && !wb_ack_i)
      else $error("flush or ack high right after reset");

endmodule

bind cp0_exc_top cp0_exc_asserts i_cp0_exc_asserts (
   .clk          (clk),
   .rst          (rst),
   .inst_valid_i (inst_valid_i),
   .fault_any_i  (pc_misalign_i | load_misalign_i | store_misalign_i | itlb_refill_i
                  | itlb_invalid_i | dtlb_refill_i | dtlb_invalid_i | dtlb_modify_i
                  | ri_i | syscall_i | break_i | overflow_i | trap_i),
   .flush_i      (flush_o),
   .wb_cyc_i     (wb_cyc_i),
   .wb_stb_i     (wb_stb_i),
   .wb_ack_i     (wb_ack_o)
);

// ==== logic/cp0_exc_top.sv ====
`timescale 1ns/10ps

module cp0_exc_top (
   input  logic        clk,
   input  logic        rst,
   input  logic        inst_valid_i,
   input  logic [31:0] inst_pc_i,
   input  logic        in_delay_slot_i,
   input  logic [31:0] data_addr_i,
   input  logic        mem_read_i,
   input  logic        mem_write_i,
   input  logic        pc_misalign_i,
   input  logic        load_misalign_i,
   input  logic        store_misalign_i,
   input  logic        itlb_refill_i,
   input  logic        itlb_invalid_i,
   input  logic        dtlb_refill_i,
   input  logic        dtlb_invalid_i,
   input  logic        dtlb_modify_i,
   input  logic        ri_i,
   input  logic        syscall_i,
   input  logic        break_i,
   input  logic        overflow_i,
   input  logic        trap_i,
   input  logic        eret_i,
   input  logic [5:0]  int_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   output logic        wb_ack_o,
   output logic [31:0] wb_dat_o,
   output logic        flush_o,
   output logic [31:0] redirect_pc_o
);

   // stage 1 record
   logic                     ex_valid;
   logic                     ex_eret;
   exc_pkg::exc_code_t       ex_code;
   logic [31:0]              ex_epc;
   logic                     ex_bd;
   cp0_reg_pkg::fault_addr_u ex_badaddr;
   logic                     ex_refill;
   logic                     ex_has_badaddr;

   logic [31:0]              status_q;
   logic [31:0]              cause_q;
   logic [31:0]              epc_q;
   logic [31:0]              ebase_q;

   // host side
   logic                     host_we;
   cp0_reg_pkg::reg_num_t    host_reg;
   cp0_reg_pkg::reg_sel_t    host_sel;
   logic [31:0]              host_wdata;
   logic [31:0]              host_rdata;

   exc_prioritize i_exc_prioritize (
      .clk, .rst,
      .inst_valid_i, .inst_pc_i, .in_delay_slot_i, .data_addr_i,
      .mem_read_i, .mem_write_i,
      .pc_misalign_i, .load_misalign_i, .store_misalign_i,
      .itlb_refill_i, .itlb_invalid_i,
      .dtlb_refill_i, .dtlb_invalid_i, .dtlb_modify_i,
      .ri_i, .syscall_i, .break_i, .overflow_i, .trap_i, .eret_i,
      .int_i,
      .status_i         (status_q),
      .cause_i          (cause_q),
      .flush_i          (flush_o),
      .ex_valid_o       (ex_valid),
      .ex_eret_o        (ex_eret),
      .ex_code_o        (ex_code),
      .ex_epc_o         (ex_epc),
      .ex_bd_o          (ex_bd),
      .ex_badaddr_o     (ex_badaddr),
      .ex_refill_o      (ex_refill),
      .ex_has_badaddr_o (ex_has_badaddr)
   );

   cp0_regfile i_cp0_regfile (
      .clk, .rst,
      .int_i,
      .ex_valid_i       (ex_valid),
      .ex_eret_i        (ex_eret),
      .ex_code_i        (ex_code),
      .ex_epc_i         (ex_epc),
      .ex_bd_i          (ex_bd),
      .ex_badaddr_i     (ex_badaddr),
      .ex_has_badaddr_i (ex_has_badaddr),
      .host_we_i        (host_we),
      .host_reg_i       (host_reg),
      .host_sel_i       (host_sel),
      .host_wdata_i     (host_wdata),
      .host_rdata_o     (host_rdata),
      .status_o         (status_q),
      .cause_o          (cause_q),
      .epc_o            (epc_q),
      .ebase_o          (ebase_q)
   );

   exc_redirect i_exc_redirect (
      .clk, .rst,
      .ex_valid_i    (ex_valid),
      .ex_eret_i     (ex_eret),
      .ex_refill_i   (ex_refill),
      .epc_i         (epc_q),
      .ebase_i       (ebase_q),
      .bev_i         (status_q[cp0_reg_pkg::STATUS_BEV]),
      .flush_o,
      .redirect_pc_o
   );

   cp0_wb_port i_cp0_wb_port (
      .clk, .rst,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
      .wb_ack_o, .wb_dat_o,
      .host_we_o    (host_we),
      .host_reg_o   (host_reg),
      .host_sel_o   (host_sel),
      .host_wdata_o (host_wdata),
      .host_rdata_i (host_rdata)
   );

endmodule

// ==== logic/cp0_wb_port.sv ====
`timescale 1ns/10ps

module cp0_wb_port (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  logic [31:0]           wb_adr_i,
   input  logic [31:0]           wb_dat_i,
   output logic                  wb_ack_o,
   output logic [31:0]           wb_dat_o,
   output logic                  host_we_o,
   output cp0_reg_pkg::reg_num_t host_reg_o,
   output cp0_reg_pkg::reg_sel_t host_sel_o,
   output logic [31:0]           host_wdata_o,
   input  logic [31:0]           host_rdata_i
);

   logic req;

   // strobe seen and not yet acked
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   assign host_we_o    = req & wb_we_i; // write lands with the ack edge
   assign host_reg_o   = wb_adr_i[6:2];
   assign host_sel_o   = wb_adr_i[9:7];
   assign host_wdata_o = wb_dat_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= req;
      end
   end

   // read data registered alongside the ack
   always_ff @(posedge clk) begin
      if (req && !wb_we_i) begin
         wb_dat_o <= host_rdata_i;
      end
   end

endmodule

// ==== logic/exc_redirect.sv ====
`timescale 1ns/10ps
`include "cp0_consts.svh"

module exc_redirect (
   input  logic        clk,
   input  logic        rst,
   input  logic        ex_valid_i,
   input  logic        ex_eret_i,
   input  logic        ex_refill_i,
   input  logic [31:0] epc_i,
   input  logic [31:0] ebase_i,
   input  logic        bev_i,
   output logic        flush_o,
   output logic [31:0] redirect_pc_o
);

   logic [31:0] vec_base;
   logic [31:0] vec_offset;
   logic [31:0] target;

   assign vec_base   = bev_i ? `CP0_BOOT_VECTOR : ebase_i;
   assign vec_offset = ex_refill_i ? exc_pkg::OFFSET_REFILL : exc_pkg::OFFSET_GENERAL;
   // eret returns through the epc as it was before this commit
   assign target = ex_eret_i ? epc_i : vec_base + vec_offset;

   always_ff @(posedge clk) begin
      if (rst) begin
         flush_o <= 1'b0;
      end else begin
         flush_o <= ex_valid_i; // one pulse per record
      end
   end

   always_ff @(posedge clk) begin
      redirect_pc_o <= target;
   end

endmodule

// ==== logic/cp0_regfile.sv ====
`timescale 1ns/10ps
`include "cp0_consts.svh"

module cp0_regfile (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [5:0]               int_i,
   input  logic                     ex_valid_i,
   input  logic                     ex_eret_i,
   input  exc_pkg::exc_code_t       ex_code_i,
   input  logic [31:0]              ex_epc_i,
   input  logic                     ex_bd_i,
   input  cp0_reg_pkg::fault_addr_u ex_badaddr_i,
   input  logic                     ex_has_badaddr_i,
   input  logic                     host_we_i,
   input  cp0_reg_pkg::reg_num_t    host_reg_i,
   input  cp0_reg_pkg::reg_sel_t    host_sel_i,
   input  logic [31:0]              host_wdata_i,
   output logic [31:0]              host_rdata_o,
   output logic [31:0]              status_o,
   output logic [31:0]              cause_o,
   output logic [31:0]              epc_o,
   output logic [31:0]              ebase_o
);

   localparam int IDX_W = $clog2(`CP0_TLB_LINES);
   localparam logic [IDX_W-1:0] RANDOM_TOP = IDX_W'(`CP0_TLB_LINES - 1);

   logic [31:0]        status_q;
   logic               bd_q;
   logic               ti_q;
   logic [1:0]         ip_sw_q;
   logic [5:0]         ip_hw_q;
   exc_pkg::exc_code_t exc_code_q;
   logic [31:0]        epc_q;
   logic [31:0]        badvaddr_q;
   logic [31:0]        count_q;
   logic               count_half_q; // count runs at half rate
   logic [31:0]        compare_q;
   logic [IDX_W-1:0]   random_q;
   logic [IDX_W-1:0]   wired_q;
   logic [31:0]        ebase_q;
   logic [IDX_W-1:0]   index_q;
   logic [31:0]        entrylo0_q;
   logic [31:0]        entrylo1_q;
   logic [31:0]        pagemask_q;
   logic [31:0]        entryhi_q;
   logic               wr_sel0;
   logic               ex_take;

   assign wr_sel0 = host_we_i & (host_sel_i == '0);
   assign ex_take = ex_valid_i & ~ex_eret_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         status_q     <= `CP0_STATUS_RESET;
         bd_q         <= 1'b0;
         ti_q         <= 1'b0;
         ip_sw_q      <= '0;
         ip_hw_q      <= '0;
         exc_code_q   <= exc_pkg::EXC_INT;
         count_q      <= '0;
         count_half_q <= 1'b0;
         compare_q    <= '0;
         random_q     <= RANDOM_TOP;
         wired_q      <= '0;
         ebase_q      <= `CP0_EBASE_RESET;
         index_q      <= '0;
         entrylo0_q   <= '0;
         entrylo1_q   <= '0;
         pagemask_q   <= '0;
         entryhi_q    <= '0;
      end else begin
         ip_hw_q      <= int_i;
         count_half_q <= ~count_half_q;
         if (count_half_q) begin
            count_q <= count_q + 32'd1;
         end
         if (compare_q != '0 && count_q == compare_q) begin
            ti_q <= 1'b1;
         end
         random_q <= (random_q == wired_q) ? RANDOM_TOP : random_q - 1'b1;

         // host writes, the exception commit below overrides them
         if (host_we_i && host_sel_i == cp0_reg_pkg::REG_EBASE_SEL &&
             host_reg_i == cp0_reg_pkg::REG_PRID) begin
            ebase_q[29:12] <= host_wdata_i[29:12];
         end
         if (wr_sel0) begin
            case (host_reg_i)
               cp0_reg_pkg::REG_STATUS:   status_q <= host_wdata_i;
               cp0_reg_pkg::REG_CAUSE:    ip_sw_q <= host_wdata_i[9:8];
               cp0_reg_pkg::REG_COUNT:    count_q <= host_wdata_i;
               cp0_reg_pkg::REG_COMPARE: begin
                  compare_q <= host_wdata_i;
                  ti_q      <= 1'b0; // compare write acks the timer
               end
               cp0_reg_pkg::REG_WIRED: begin
                  wired_q  <= host_wdata_i[IDX_W-1:0];
                  random_q <= RANDOM_TOP;
               end
               cp0_reg_pkg::REG_INDEX:    index_q <= host_wdata_i[IDX_W-1:0];
               cp0_reg_pkg::REG_ENTRYLO0: entrylo0_q <= host_wdata_i & cp0_reg_pkg::MASK_ENTRYLO;
               cp0_reg_pkg::REG_ENTRYLO1: entrylo1_q <= host_wdata_i & cp0_reg_pkg::MASK_ENTRYLO;
               cp0_reg_pkg::REG_PAGEMASK: pagemask_q <= host_wdata_i & cp0_reg_pkg::MASK_PAGEMASK;
               cp0_reg_pkg::REG_ENTRYHI:  entryhi_q <= host_wdata_i & cp0_reg_pkg::MASK_ENTRYHI;
               default: ;
            endcase
         end

         if (ex_valid_i && ex_eret_i) begin
            status_q[cp0_reg_pkg::STATUS_EXL] <= 1'b0;
         end
         if (ex_take) begin
            status_q[cp0_reg_pkg::STATUS_EXL] <= 1'b1;
            bd_q       <= ex_bd_i;
            exc_code_q <= ex_code_i;
            if (ex_code_i inside {exc_pkg::EXC_MOD, exc_pkg::EXC_TLBL, exc_pkg::EXC_TLBS}) begin
               entryhi_q[31:13] <= ex_badaddr_i.page.vpn2;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_sel0 && host_reg_i == cp0_reg_pkg::REG_EPC) begin
         epc_q <= host_wdata_i;
      end
      if (ex_take) begin
         epc_q <= ex_epc_i; // no exl protection, always rewritten
      end
      if (ex_take && ex_has_badaddr_i) begin
         badvaddr_q <= ex_badaddr_i.vaddr;
      end
   end

   // ip7 shows the timer as well
   assign cause_o = {bd_q, ti_q, 14'd0, ip_hw_q[5] | ti_q, ip_hw_q[4:0], ip_sw_q,
                     1'b0, exc_code_q, 2'd0};
   assign status_o = status_q;
   assign epc_o    = epc_q;
   assign ebase_o  = ebase_q;

   always_comb begin
      host_rdata_o = '0;
      if (host_sel_i == cp0_reg_pkg::REG_EBASE_SEL) begin
         if (host_reg_i == cp0_reg_pkg::REG_PRID) begin
            host_rdata_o = ebase_q;
         end
      end else if (host_sel_i == '0) begin
         case (host_reg_i)
            cp0_reg_pkg::REG_INDEX:    host_rdata_o = 32'(index_q);
            cp0_reg_pkg::REG_RANDOM:   host_rdata_o = 32'(random_q);
            cp0_reg_pkg::REG_ENTRYLO0: host_rdata_o = entrylo0_q;
            cp0_reg_pkg::REG_ENTRYLO1: host_rdata_o = entrylo1_q;
            cp0_reg_pkg::REG_PAGEMASK: host_rdata_o = pagemask_q;
            cp0_reg_pkg::REG_WIRED:    host_rdata_o = 32'(wired_q);
            cp0_reg_pkg::REG_BADVADDR: host_rdata_o = badvaddr_q;
            cp0_reg_pkg::REG_COUNT:    host_rdata_o = count_q;
            cp0_reg_pkg::REG_ENTRYHI:  host_rdata_o = entryhi_q;
            cp0_reg_pkg::REG_COMPARE:  host_rdata_o = compare_q;
            cp0_reg_pkg::REG_STATUS:   host_rdata_o = status_q;
            cp0_reg_pkg::REG_CAUSE:    host_rdata_o = cause_o;
            cp0_reg_pkg::REG_EPC:      host_rdata_o = epc_q;
            cp0_reg_pkg::REG_PRID:     host_rdata_o = `CP0_PRID_VALUE;
            cp0_reg_pkg::REG_CONFIG:   host_rdata_o = `CP0_CONFIG_RESET;
            default:                   host_rdata_o = '0;
         endcase
      end
   end

endmodule

// ==== logic/exc_prioritize.sv ====
`timescale 1ns/10ps

module exc_prioritize (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     inst_valid_i,
   input  logic [31:0]              inst_pc_i,
   input  logic                     in_delay_slot_i,
   input  logic [31:0]              data_addr_i,
   input  logic                     mem_read_i,
   input  logic                     mem_write_i,
   input  logic                     pc_misalign_i,
   input  logic                     load_misalign_i,
   input  logic                     store_misalign_i,
   input  logic                     itlb_refill_i,
   input  logic                     itlb_invalid_i,
   input  logic                     dtlb_refill_i,
   input  logic                     dtlb_invalid_i,
   input  logic                     dtlb_modify_i,
   input  logic                     ri_i,
   input  logic                     syscall_i,
   input  logic                     break_i,
   input  logic                     overflow_i,
   input  logic                     trap_i,
   input  logic                     eret_i,
   input  logic [5:0]               int_i,
   input  logic [31:0]              status_i,
   input  logic [31:0]              cause_i,
   input  logic                     flush_i,
   output logic                     ex_valid_o,
   output logic                     ex_eret_o,
   output exc_pkg::exc_code_t       ex_code_o,
   output logic [31:0]              ex_epc_o,
   output logic                     ex_bd_o,
   output cp0_reg_pkg::fault_addr_u ex_badaddr_o,
   output logic                     ex_refill_o,
   output logic                     ex_has_badaddr_o
);

   logic [7:0]         ip_bits;
   logic               int_pending;
   logic               dtlb_miss;
   exc_pkg::exc_code_t code;
   logic               refill;
   logic               fault;
   logic               take;
   logic               has_bad;

   // ip7 carries the timer, hw lines live, sw bits from cause
   assign ip_bits = {int_i[5] | cause_i[30], int_i[4:0], cause_i[9:8]};
   assign int_pending = status_i[cp0_reg_pkg::STATUS_IE] & ~status_i[cp0_reg_pkg::STATUS_EXL]
                        & |(status_i[15:8] & ip_bits);
   assign dtlb_miss = dtlb_refill_i | dtlb_invalid_i;

   always_comb begin
      code   = exc_pkg::EXC_INT;
      refill = 1'b0;
      fault  = 1'b1;
      if (int_pending) begin
         code = exc_pkg::EXC_INT;
      end else if (itlb_refill_i || itlb_invalid_i) begin
         code   = exc_pkg::EXC_TLBL;
         refill = itlb_refill_i;
      end else if (mem_read_i && dtlb_miss) begin
         code   = exc_pkg::EXC_TLBL;
         refill = dtlb_refill_i;
      end else if (mem_write_i && dtlb_miss) begin
         code   = exc_pkg::EXC_TLBS;
         refill = dtlb_refill_i;
      end else if (dtlb_modify_i) begin
         code = exc_pkg::EXC_MOD;
      end else if (pc_misalign_i || load_misalign_i) begin
         code = exc_pkg::EXC_ADEL;
      end else if (ri_i) begin
         code = exc_pkg::EXC_RI;
      end else if (syscall_i) begin
         code = exc_pkg::EXC_SYS;
      end else if (break_i) begin
         code = exc_pkg::EXC_BP;
      end else if (store_misalign_i) begin
         code = exc_pkg::EXC_ADES;
      end else if (overflow_i) begin
         code = exc_pkg::EXC_OV;
      end else if (trap_i) begin
         code = exc_pkg::EXC_TR;
      end else begin
         fault = 1'b0; // only eret left
      end
   end

   assign take = inst_valid_i & ~flush_i & (fault | eret_i);
   assign has_bad = fault & (code inside {exc_pkg::EXC_MOD, exc_pkg::EXC_TLBL,
                                          exc_pkg::EXC_TLBS, exc_pkg::EXC_ADEL,
                                          exc_pkg::EXC_ADES});

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_valid_o <= 1'b0;
         ex_eret_o  <= 1'b0;
      end else begin
         ex_valid_o <= take;
         ex_eret_o  <= take & ~fault;
      end
   end

   // record payload
   always_ff @(posedge clk) begin
      ex_code_o        <= code;
      ex_epc_o         <= in_delay_slot_i ? inst_pc_i - 32'd4 : inst_pc_i;
      ex_bd_o          <= in_delay_slot_i;
      ex_refill_o      <= refill;
      ex_has_badaddr_o <= has_bad;
      // fetch side faults report the pc
      ex_badaddr_o.vaddr <= (pc_misalign_i | itlb_refill_i | itlb_invalid_i) ?
                            inst_pc_i : data_addr_i;
   end

endmodule

// ==== logic/exc_pkg.sv ====
package exc_pkg;

   // cause.exccode values
   typedef enum logic [4:0] {
      EXC_INT  = 5'd0,
      EXC_MOD  = 5'd1,
      EXC_TLBL = 5'd2,
      EXC_TLBS = 5'd3,
      EXC_ADEL = 5'd4,
      EXC_ADES = 5'd5,
      EXC_SYS  = 5'd8,
      EXC_BP   = 5'd9,
      EXC_RI   = 5'd10,
      EXC_OV   = 5'd12,
      EXC_TR   = 5'd13
   } exc_code_t;

   // priority, highest first
   //   interrupt, itlb miss, dtlb load miss, dtlb store miss, tlb modify,
   //   pc or load misalign, ri, syscall, break, store misalign,
   //   overflow, trap, and eret last

   localparam logic [31:0] OFFSET_REFILL  = 32'h0000_0000;
   localparam logic [31:0] OFFSET_GENERAL = 32'h0000_0180;

endpackage

// ==== logic/cp0_reg_pkg.sv ====
package cp0_reg_pkg;

   localparam int SEL_W = 3;

   typedef logic [4:0]       reg_num_t;
   typedef logic [SEL_W-1:0] reg_sel_t;

   // cp0 register numbers, select 0 unless noted
   localparam reg_num_t REG_INDEX    = 5'd0;
   localparam reg_num_t REG_RANDOM   = 5'd1;
   localparam reg_num_t REG_ENTRYLO0 = 5'd2;
   localparam reg_num_t REG_ENTRYLO1 = 5'd3;
   localparam reg_num_t REG_PAGEMASK = 5'd5;
   localparam reg_num_t REG_WIRED    = 5'd6;
   localparam reg_num_t REG_BADVADDR = 5'd8;
   localparam reg_num_t REG_COUNT    = 5'd9;
   localparam reg_num_t REG_ENTRYHI  = 5'd10;
   localparam reg_num_t REG_COMPARE  = 5'd11;
   localparam reg_num_t REG_STATUS   = 5'd12;
   localparam reg_num_t REG_CAUSE    = 5'd13;
   localparam reg_num_t REG_EPC      = 5'd14;
   localparam reg_num_t REG_PRID     = 5'd15;
   localparam reg_num_t REG_CONFIG   = 5'd16;
   localparam reg_sel_t REG_EBASE_SEL = 3'd1; // ebase is reg 15 sel 1

   // status bit positions
   localparam int STATUS_IE  = 0;
   localparam int STATUS_EXL = 1;
   localparam int STATUS_BEV = 22;

   // architected fields of the tlb registers
   localparam logic [31:0] MASK_ENTRYLO = 32'h3FFF_FFFF; // pfn, c, d, v, g
   localparam logic [31:0] MASK_PAGEMASK = 32'h1FFF_E000;
   localparam logic [31:0] MASK_ENTRYHI = 32'hFFFF_E0FF; // vpn2, asid

   // faulting address, flat for badvaddr, split for entryhi
   typedef union packed {
      logic [31:0] vaddr;
      struct packed {
         logic [18:0] vpn2;
         logic [12:0] offset;
      } page;
   } fault_addr_u;

endpackage

// ==== logic/cp0_consts.svh ====
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// tlb entries, sets random and wired width
`define CP0_TLB_LINES 16

// register reset words
`define CP0_STATUS_RESET 32'h0040_0000 // bev set
`define CP0_CONFIG_RESET 32'h0000_8000 // big endian, mips32r1
`define CP0_PRID_VALUE   32'h0001_8003
`define CP0_EBASE_RESET  32'h8000_0000

// vector base while status.bev is set
`define CP0_BOOT_VECTOR  32'hBFC0_0200

`endif
